/* design/vecPkg.sv */
package vecPkg;

    typedef logic [31:0] wordT;     // One element operand or result
    typedef logic [4:0]  shamtT;    // Shift amount, never wider than SEW32 needs
    typedef logic [32:0] wideT;     // Word plus carry or borrow bit

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sewT;

    typedef enum logic [4:0] {
        // Integer arithmetic
        OP_ADD   = 5'h00,
        OP_SUB   = 5'h01,    // A - B
        OP_RSB   = 5'h02,    // B - A
        OP_ADC   = 5'h03,    // Mask is carry in
        OP_SBC   = 5'h04,    // Mask is borrow in
        OP_MADC  = 5'h05,    // Carry out only
        OP_MSBC  = 5'h06,    // Unsigned borrow out only
        // Bitwise
        OP_AND   = 5'h07,
        OP_OR    = 5'h08,
        OP_XOR   = 5'h09,
        // Shifts
        OP_SLL   = 5'h0a,
        OP_SRL   = 5'h0b,
        OP_SRA   = 5'h0c,
        // Compares give 0 or 1
        OP_SEQ   = 5'h0d,
        OP_SNE   = 5'h0e,
        OP_SLT   = 5'h0f,
        OP_SLTU  = 5'h10,
        OP_SLE   = 5'h11,
        OP_SLEU  = 5'h12,
        OP_SGT   = 5'h13,
        OP_SGTU  = 5'h14,
        OP_MIN   = 5'h15,
        OP_MINU  = 5'h16,
        OP_MAX   = 5'h17,
        OP_MAXU  = 5'h18,
        // Data movement
        OP_MERGE = 5'h19,    // Mask selects B
        OP_MV    = 5'h1a,
        // Multiplier unit
        OP_MUL   = 5'h1b,    // Low word
        OP_MULH  = 5'h1c,    // Signed high word
        OP_MULHU = 5'h1d     // Unsigned high word
    } vecOpT;

endpackage

/* design/vecAlu.sv */
`timescale 1ns/1ps

module vecAlu (
    input  vecPkg::wordT  opA,
    input  vecPkg::wordT  opB,
    input  logic          maskBit,
    input  vecPkg::vecOpT op,
    input  vecPkg::sewT   sew,
    output vecPkg::wordT  aluResult
);

    vecPkg::shamtT shamt;
    vecPkg::wideT  carrySum;
    vecPkg::wideT  borrowDiff;
    logic          ltSigned;
    logic          ltUnsigned;
    logic          equal;

    // Only the low bits selected by the element width count
    always_comb begin
        case (sew)
            vecPkg::SEW8:  shamt = {2'b00, opB[2:0]};
            vecPkg::SEW16: shamt = {1'b0, opB[3:0]};
            default:       shamt = opB[4:0];
        endcase
    end

    assign carrySum   = {1'b0, opA} + {1'b0, opB} + {32'b0, maskBit};
    assign borrowDiff = {1'b0, opA} - {1'b0, opB} - {32'b0, maskBit};  // Bit 32 set on borrow

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;
    assign equal      = opA == opB;

    always_comb begin
        aluResult = '0;
        case (op)
            vecPkg::OP_ADD:   aluResult = opA + opB;
            vecPkg::OP_SUB:   aluResult = opA - opB;
            vecPkg::OP_RSB:   aluResult = opB - opA;
            vecPkg::OP_ADC:   aluResult = carrySum[31:0];
            vecPkg::OP_SBC:   aluResult = borrowDiff[31:0];
            vecPkg::OP_MADC:  aluResult = {31'b0, carrySum[32]};
            vecPkg::OP_MSBC:  aluResult = {31'b0, borrowDiff[32]};
            vecPkg::OP_AND:   aluResult = opA & opB;
            vecPkg::OP_OR:    aluResult = opA | opB;
            vecPkg::OP_XOR:   aluResult = opA ^ opB;
            vecPkg::OP_SLL:   aluResult = opA << shamt;
            vecPkg::OP_SRL:   aluResult = opA >> shamt;
            vecPkg::OP_SRA:   aluResult = $signed(opA) >>> shamt;  // Sign fill
            vecPkg::OP_SEQ:   aluResult = {31'b0, equal};
            vecPkg::OP_SNE:   aluResult = {31'b0, !equal};
            vecPkg::OP_SLT:   aluResult = {31'b0, ltSigned};
            vecPkg::OP_SLTU:  aluResult = {31'b0, ltUnsigned};
            vecPkg::OP_SLE:   aluResult = {31'b0, ltSigned | equal};
            vecPkg::OP_SLEU:  aluResult = {31'b0, ltUnsigned | equal};
            vecPkg::OP_SGT:   aluResult = {31'b0, !(ltSigned | equal)};
            vecPkg::OP_SGTU:  aluResult = {31'b0, !(ltUnsigned | equal)};
            vecPkg::OP_MIN:   aluResult = ltSigned ? opA : opB;
            vecPkg::OP_MINU:  aluResult = ltUnsigned ? opA : opB;
            vecPkg::OP_MAX:   aluResult = ltSigned ? opB : opA;
            vecPkg::OP_MAXU:  aluResult = ltUnsigned ? opB : opA;
            vecPkg::OP_MERGE: aluResult = maskBit ? opB : opA;
            vecPkg::OP_MV:    aluResult = opB;
            default:          aluResult = '0;  // Multiply codes land here
        endcase
    end

endmodule

/* design/vecMultiplier.sv */
`timescale 1ns/1ps

module vecMultiplier #(
    parameter int bitsPerCycle = 4
) (
    input  logic          CLK,
    input  logic          rstN,
    input  logic          start,
    input  vecPkg::wordT  mulA,
    input  vecPkg::wordT  mulB,
    input  vecPkg::vecOpT mulOp,
    output logic          busy,
    output vecPkg::wordT  productLo,
    output vecPkg::wordT  productHi
);

    localparam int steps = 32 / bitsPerCycle;
    localparam int cntW  = $clog2(steps + 1);

    logic            signedOp;
    vecPkg::wordT    magA;
    vecPkg::wordT    magB;
    logic [63:0]     mcand;      // Moves left each step
    vecPkg::wordT    mplier;     // Moves right each step
    logic [63:0]     acc;
    logic [63:0]     addend;
    logic [63:0]     accNext;
    logic            negate;
    logic [cntW-1:0] stepsLeft;
    logic            lastStep;

    assign signedOp = (mulOp == vecPkg::OP_MULH);
    assign magA     = (signedOp && mulA[31]) ? -mulA : mulA;
    assign magB     = (signedOp && mulB[31]) ? -mulB : mulB;

    assign busy     = (stepsLeft != '0);
    assign lastStep = (stepsLeft == cntW'(1));

    // Shift-add over the low multiplier bits of this step
    always_comb begin
        addend = '0;
        for (int i = 0; i < bitsPerCycle; i++) begin
            if (mplier[i]) begin
                addend = addend + (mcand << i);
            end
        end
        accNext = acc + addend;
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            stepsLeft <= '0;
            negate    <= 1'b0;
        end else if (start) begin
            stepsLeft <= cntW'(steps);
            negate    <= signedOp & (mulA[31] ^ mulB[31]);
        end else if (busy) begin
            stepsLeft <= stepsLeft - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            mcand  <= {32'b0, magA};
            mplier <= magB;
            acc    <= '0;
        end else if (busy) begin
            mcand  <= mcand << bitsPerCycle;
            mplier <= mplier >> bitsPerCycle;
            if (lastStep && negate) begin
                acc <= -accNext;  // Sign goes on with the last bits
            end else begin
                acc <= accNext;
            end
        end
    end

    assign productLo = acc[31:0];
    assign productHi = acc[63:32];

endmodule

/* design/vecFuncUnit.sv */
`timescale 1ns/1ps

module vecFuncUnit #(
    parameter int bitsPerCycle = 4
) (
    input  logic          CLK,
    input  logic          rstN,
    input  vecPkg::wordT  fuOpA,
    input  vecPkg::wordT  fuOpB,
    input  logic          fuMask,
    input  vecPkg::vecOpT fuOp,
    input  vecPkg::sewT   fuSew,
    input  logic          start,
    output logic          stall,
    output vecPkg::wordT  fuResult
);

    logic         isMul;
    logic         mulStart;
    logic         mulBusy;
    vecPkg::wordT aluResult;
    vecPkg::wordT productLo;
    vecPkg::wordT productHi;

    assign isMul = (fuOp == vecPkg::OP_MUL) || (fuOp == vecPkg::OP_MULH) ||
                   (fuOp == vecPkg::OP_MULHU);

    assign mulStart = start & isMul;  // ALU ops leave the multiplier idle
    assign stall    = isMul & mulBusy;

    vecAlu vecAlu_i (
        .opA       (fuOpA),
        .opB       (fuOpB),
        .maskBit   (fuMask),
        .op        (fuOp),
        .sew       (fuSew),
        .aluResult (aluResult)
    );

    vecMultiplier #(
        .bitsPerCycle (bitsPerCycle)
    ) vecMultiplier_i (
        .CLK       (CLK),
        .rstN      (rstN),
        .start     (mulStart),
        .mulA      (fuOpA),
        .mulB      (fuOpB),
        .mulOp     (fuOp),
        .busy      (mulBusy),
        .productLo (productLo),
        .productHi (productHi)
    );

    always_comb begin
        if (!isMul) begin
            fuResult = aluResult;
        end else if (fuOp == vecPkg::OP_MUL) begin
            fuResult = productLo;
        end else begin
            fuResult = productHi;
        end
    end

endmodule

/* design/vecLaneCtrl.sv */
`timescale 1ns/1ps

module vecLaneCtrl (
    input  logic          CLK,
    input  logic          rstN,
    input  logic          req,
    output logic          ack,
    input  vecPkg::wordT  opA,
    input  vecPkg::wordT  opB,
    input  logic          maskBit,
    input  vecPkg::vecOpT op,
    input  vecPkg::sewT   sew,
    output vecPkg::wordT  result,
    output vecPkg::wordT  fuOpA,
    output vecPkg::wordT  fuOpB,
    output logic          fuMask,
    output vecPkg::vecOpT fuOp,
    output vecPkg::sewT   fuSew,
    output logic          start,
    input  logic          stall,
    input  vecPkg::wordT  fuResult
);

    typedef enum logic [2:0] {
        IDLE,
        EXEC,      // Start pulse is out
        WAIT,      // Wait for the unit to finish
        DONE,      // Ack high, result held
        RELEASE
    } laneStateT;

    laneStateT state;
    logic      accept;

    assign accept = (state == IDLE) && req;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state  <= IDLE;
            ack    <= 1'b0;
            start  <= 1'b0;
            result <= '0;
        end else begin
            start <= accept;
            case (state)
                IDLE: begin
                    if (req) state <= EXEC;
                end
                EXEC: state <= WAIT;  // Multiplier busy shows up one cycle later
                WAIT: begin
                    if (!stall) begin
                        result <= fuResult;
                        ack    <= 1'b1;
                        state  <= DONE;
                    end
                end
                DONE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands stay put until the next request
    always_ff @(posedge CLK) begin
        if (accept) begin
            fuOpA  <= opA;
            fuOpB  <= opB;
            fuMask <= maskBit;
            fuOp   <= op;
            fuSew  <= sew;
        end
    end

endmodule

/* design/vecLaneTop.sv */
`timescale 1ns/1ps

module vecLaneTop #(
    parameter int bitsPerCycle = 4
) (
    input  logic          CLK,
    input  logic          rstN,
    input  logic          req,
    output logic          ack,
    input  vecPkg::wordT  opA,
    input  vecPkg::wordT  opB,
    input  logic          maskBit,
    input  vecPkg::vecOpT op,
    input  vecPkg::sewT   sew,
    output vecPkg::wordT  result
);

    vecPkg::wordT  fuOpA;
    vecPkg::wordT  fuOpB;
    logic          fuMask;
    vecPkg::vecOpT fuOp;
    vecPkg::sewT   fuSew;
    logic          start;
    logic          stall;
    vecPkg::wordT  fuResult;

    vecLaneCtrl vecLaneCtrl_i (
        .CLK      (CLK),
        .rstN     (rstN),
        .req      (req),
        .ack      (ack),
        .opA      (opA),
        .opB      (opB),
        .maskBit  (maskBit),
        .op       (op),
        .sew      (sew),
        .result   (result),
        .fuOpA    (fuOpA),
        .fuOpB    (fuOpB),
        .fuMask   (fuMask),
        .fuOp     (fuOp),
        .fuSew    (fuSew),
        .start    (start),
        .stall    (stall),
        .fuResult (fuResult)
    );

    vecFuncUnit #(
        .bitsPerCycle (bitsPerCycle)
    ) vecFuncUnit_i (
        .CLK      (CLK),
        .rstN     (rstN),
        .fuOpA    (fuOpA),
        .fuOpB    (fuOpB),
        .fuMask   (fuMask),
        .fuOp     (fuOp),
        .fuSew    (fuSew),
        .start    (start),
        .stall    (stall),
        .fuResult (fuResult)
    );

endmodule

/* tb/vecLane_assert.sv */
`timescale 1ns/1ps

module vecLaneAssert (
    input logic         CLK,
    input logic         rstN,
    input logic         req,
    input logic         ack,
    input vecPkg::wordT result
);

    int failCount = 0;

    ackRiseWithReq: assert property (@(posedge CLK) disable iff (!rstN)
        $rose(ack) |-> $past(req))
        else begin
            failCount++;
            $error("ack rose without req high");
        end

    ackFallAfterReq: assert property (@(posedge CLK) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
        else begin
            failCount++;
            $error("ack fell while req was still high");
        end

    resultHeld: assert property (@(posedge CLK) disable iff (!rstN)
        (ack && $past(ack)) |-> $stable(result))
        else begin
            failCount++;
            $error("result changed while ack was high");
        end

    // First sample out of reset
    ackLowAfterReset: assert property (@(posedge CLK)
        $rose(rstN) |-> !ack)
        else begin
            failCount++;
            $error("ack high right after reset release");
        end

endmodule

bind vecLaneTop vecLaneAssert vecLaneAssert_i (
    .CLK    (CLK),
    .rstN   (rstN),
    .req    (req),
    .ack    (ack),
    .result (result)
);

/* tb/vecLaneTb.sv */
`timescale 1ns/1ps

module vecLaneTb;

    localparam int bitsPerCycle = 4;
    localparam int aluEdges     = 2;
    localparam int mulEdges     = 32 / bitsPerCycle + 2;
    localparam int holdIndex    = 26;  // Multiply vector held under back-pressure
    localparam int holdCycles   = 5;

    logic          CLK;
    logic          rstN;
    logic          req;
    logic          ack;
    vecPkg::wordT  opA;
    vecPkg::wordT  opB;
    logic          maskBit;
    vecPkg::vecOpT op;
    vecPkg::sewT   sew;
    vecPkg::wordT  result;

    logic [4:0]    opList[$];
    logic [1:0]    sewList[$];
    logic          maskList[$];
    vecPkg::wordT  aList[$];
    vecPkg::wordT  bList[$];
    vecPkg::wordT  expList[$];

    int errors     = 0;
    int checks     = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    vecLaneTop #(
        .bitsPerCycle (bitsPerCycle)
    ) vecLaneTop_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .req     (req),
        .ack     (ack),
        .opA     (opA),
        .opB     (opB),
        .maskBit (maskBit),
        .op      (op),
        .sew     (sew),
        .result  (result)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles with vectors left", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    task automatic checkWord(input string name, input vecPkg::wordT actual,
                             input vecPkg::wordT expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic checkLatency(input string name, input int measured, input int expected);
        checks++;
        if (measured != expected) begin
            errors++;
            $display("mismatch %s: got %h edges expected %h", name, measured, expected);
        end
    endtask

    function automatic logic isMultiply(input logic [4:0] code);
        return (code == vecPkg::OP_MUL) || (code == vecPkg::OP_MULH) ||
               (code == vecPkg::OP_MULHU);
    endfunction

    task automatic loadVectors();
        int fd;
        int got;
        string line;
        logic [31:0] fOp, fSew, fMask, fA, fB, fExp;
        fd = $fopen("tb/vecStim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open stimulus file tb/vecStim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                got = $sscanf(line, "%h %h %h %h %h %h", fOp, fSew, fMask, fA, fB, fExp);
                if (got == 6) begin  // Comment and blank lines drop out here
                    opList.push_back(fOp[4:0]);
                    sewList.push_back(fSew[1:0]);
                    maskList.push_back(fMask[0]);
                    aList.push_back(fA);
                    bList.push_back(fB);
                    expList.push_back(fExp);
                end
            end
            $fclose(fd);
            if (opList.size() == 0) begin
                errors++;
                $display("Stimulus file holds no vectors");
            end
        end
    endtask

    // Called 2 ns after a rising edge with the lane idle
    task automatic runVector(input int idx);
        int edges;
        opA     = aList[idx];
        opB     = bList[idx];
        maskBit = maskList[idx];
        op      = vecPkg::vecOpT'(opList[idx]);
        sew     = vecPkg::sewT'(sewList[idx]);
        req     = 1'b1;
        @(posedge CLK);  // Edge that samples req
        edges = 0;
        @(negedge CLK);
        while (!ack) begin
            @(posedge CLK);
            edges++;
            @(negedge CLK);
        end
        checkLatency("ack rise", edges, isMultiply(opList[idx]) ? mulEdges : aluEdges);
        checkWord("result", result, expList[idx]);
        if (idx == holdIndex) begin
            repeat (holdCycles) begin
                @(negedge CLK);
                checkFlag("ack", ack, 1'b1);
                checkWord("result", result, expList[idx]);
            end
        end
        @(posedge CLK);
        #2 req = 1'b0;
        edges = 0;
        while (ack) begin
            @(posedge CLK);
            edges++;
            @(negedge CLK);
        end
        checkLatency("ack fall", edges, 1);
        @(posedge CLK);  // Controller passes through RELEASE
        #2;
    endtask

    initial begin
        rstN    = 1'b0;
        req     = 1'b0;
        opA     = '0;
        opB     = '0;
        maskBit = 1'b0;
        op      = vecPkg::OP_ADD;
        sew     = vecPkg::SEW32;
        loadVectors();
        cycleLimit = opList.size() * (32 / bitsPerCycle + 10) + 100;
        repeat (2) @(posedge CLK);
        #2 rstN = 1'b1;
        @(negedge CLK);
        checkFlag("ack", ack, 1'b0);
        checkWord("result", result, '0);
        @(posedge CLK);
        #2;
        for (int i = 0; i < opList.size(); i++) begin
            runVector(i);
        end
        errors = errors + vecLaneTop_i.vecLaneAssert_i.failCount;  // Bound checker failures
        $display("%0d errors in %0d checks over %0d vectors", errors, checks, opList.size());
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tb/vecStim.txt */
# op sew mask opA opB expected, all hex
# sew 0=SEW8 1=SEW16 2=SEW32
00 2 0 7fffffff 00000001 80000000
00 2 0 ffffffff 00000002 00000001
01 2 0 00000005 00000007 fffffffe
02 2 0 00000005 00000007 00000002
07 2 0 f0f0a5a5 0ff05a5a 00f00000
08 2 0 f0f0a5a5 0ff05a5a fff0ffff
09 2 0 f0f0a5a5 0ff05a5a ff00ffff
1a 2 1 12345678 9abcdef0 9abcdef0
03 2 0 ffffffff 00000000 ffffffff
03 2 1 ffffffff 00000000 00000000
04 2 1 00000010 00000003 0000000c
05 2 1 ffffffff 00000000 00000001
06 2 0 00000003 00000003 00000000
06 2 1 00000003 00000003 00000001
19 2 0 11111111 22222222 11111111
19 2 1 11111111 22222222 22222222
0a 0 0 00000001 000000fb 00000008
0b 1 0 80000000 000000f4 08000000
0c 2 0 80000000 ffffffe4 f8000000
0f 2 0 80000000 00000000 00000001
10 2 0 80000000 00000000 00000000
14 2 0 80000000 00000000 00000001
11 2 0 80000000 80000000 00000001
15 2 0 80000000 00000000 80000000
18 2 0 80000000 00000000 80000000
1b 2 0 00001234 00005678 06260060
1c 2 0 fffffffe 00000003 ffffffff
1d 2 0 ffffffff ffffffff fffffffe
1c 2 1 ffffffff ffffffff 00000000

/* vlog.f */
design/vecPkg.sv
design/vecAlu.sv
design/vecMultiplier.sv
design/vecFuncUnit.sv
design/vecLaneCtrl.sv
design/vecLaneTop.sv
tb/vecLane_assert.sv
tb/vecLaneTb.sv

/* Bender.yml */
package:
  name: vec_lane

sources:
  - design/vecPkg.sv
  - design/vecAlu.sv
  - design/vecMultiplier.sv
  - design/vecFuncUnit.sv
  - design/vecLaneCtrl.sv
  - design/vecLaneTop.sv
  - target: test
    files:
      - tb/vecLane_assert.sv
      - tb/vecLaneTb.sv
